//--- common/qdr_rd_pkg.sv
package qdr_rd_pkg;

	// latency count covers every candidate tap of the read-valid shifter
	localparam int LAT_W = 3;
	localparam int LAT_NUM = 8;

	// the return FIFO depth is also the number of credits the user may hold
	localparam int RET_DEPTH = 4;
	localparam int RET_PTR_W = 2;
	localparam int RET_CNT_W = 3;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 36;

	// one trial is a single issue cycle, a fixed wait window and a check cycle
	localparam int CAL_TRIAL_CYCLES = 12;
	localparam int CAL_WAIT_CYCLES = CAL_TRIAL_CYCLES - 2;
	localparam int CAL_WAIT_W = 4;

	typedef logic [LAT_W-1:0] lat_count_t;
	typedef logic [LAT_NUM-1:0] lat_vec_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// the calibration word must differ from the idle bus value of zero
	localparam addr_t CAL_ADDR = 16'h0a5c;
	localparam data_t CAL_PATTERN = 36'h9_c3a5_5a3c;

	// registered read command as it leaves for the SRAM
	typedef struct packed {
		logic rd;
		addr_t addr;
	} mem_cmd_t;

	// read request from the calibrator or from the user port
	typedef struct packed {
		logic valid;
		addr_t addr;
	} rd_req_t;

	// head of the return FIFO
	typedef struct packed {
		logic valid;
		data_t data;
	} rd_rsp_t;

	typedef enum logic [2:0] {IDLE, ISSUE, WAIT, CHECK, DONE, FAIL} cal_state_t;

endpackage

//--- rtl/read_cmd_arbiter.sv
`timescale 1ns/1ps

module read_cmd_arbiter (
	input logic pll_afi_clk,
	input logic reset_n,
	input qdr_rd_pkg::rd_req_t cal_req,
	input qdr_rd_pkg::rd_req_t user_req,
	output qdr_rd_pkg::mem_cmd_t mem_cmd,
	output logic issue,
	output logic issue_owner
);
	import qdr_rd_pkg::*;

	// a user request that lost against the calibrator waits here for one cycle
	rd_req_t hold;

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			mem_cmd <= '0;
			issue <= 1'b0;
			issue_owner <= 1'b0;
			hold <= '0;
		end
		else
		begin
			if (cal_req.valid)
			begin
				// calibrator always wins and is tagged with owner 0
				mem_cmd.rd <= 1'b1;
				mem_cmd.addr <= cal_req.addr;
				issue <= 1'b1;
				issue_owner <= 1'b0;
				if (user_req.valid)
					hold <= user_req;
			end
			else if (hold.valid)
			begin
				// the held request goes first so user reads stay in order
				mem_cmd.rd <= 1'b1;
				mem_cmd.addr <= hold.addr;
				issue <= 1'b1;
				issue_owner <= 1'b1;
				hold <= user_req;
			end
			else if (user_req.valid)
			begin
				mem_cmd.rd <= 1'b1;
				mem_cmd.addr <= user_req.addr;
				issue <= 1'b1;
				issue_owner <= 1'b1;
			end
			else
			begin
				// address is left as it was, only the strobe drops
				mem_cmd.rd <= 1'b0;
				issue <= 1'b0;
				issue_owner <= 1'b0;
			end
		end
	end

	// the calibrator spaces its reads a full trial apart, so a collision never
	// finds the hold register still occupied
	a_hold_free: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		(cal_req.valid && user_req.valid) |-> !hold.valid);

endmodule

//--- read_path/read_latency_shifter.sv
`timescale 1ns/1ps

module read_latency_shifter (
	input logic pll_afi_clk,
	input logic reset_n,
	input logic issue,
	input logic issue_owner,
	output qdr_rd_pkg::lat_vec_t lat_shift,
	output qdr_rd_pkg::lat_vec_t owner_shift
);
	import qdr_rd_pkg::*;

	// owner is only meaningful together with a valid read
	logic owner_in;

	assign owner_in = issue & issue_owner;

	// tap k holds the read that was issued k+1 cycles ago
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			lat_shift <= '0;
		end
		else
		begin
			lat_shift <= {lat_shift[LAT_NUM-2:0], issue};
		end
	end

	// the owner bits age in lock step with the valid bits
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			owner_shift <= '0;
		end
		else
		begin
			owner_shift <= {owner_shift[LAT_NUM-2:0], owner_in};
		end
	end

endmodule

//--- read_path/read_valid_selector.sv
`timescale 1ns/1ps

module read_valid_selector (
	input logic pll_afi_clk,
	input logic reset_n,
	input qdr_rd_pkg::lat_vec_t lat_shift,
	input qdr_rd_pkg::lat_vec_t owner_shift,
	input qdr_rd_pkg::lat_count_t lat_count,
	output logic read_valid,
	output logic read_owner
);
	import qdr_rd_pkg::*;

	lat_vec_t sel_next;
	lat_vec_t sel_reg;
	lat_vec_t valid_hit;
	lat_vec_t owner_hit;

	// one-hot decode of the latency count into a shifter tap
	assign sel_next = lat_vec_t'(1) << lat_count;

	// the select comes out of reset pointing at tap 0 so it is always one-hot
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			sel_reg <= lat_vec_t'(1);
		else
			sel_reg <= sel_next;
	end

	assign valid_hit = sel_reg & lat_shift;
	assign owner_hit = sel_reg & owner_shift;

	// read_valid lands in the cycle the SRAM drives the matching word
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_valid <= 1'b0;
			read_owner <= 1'b0;
		end
		else
		begin
			read_valid <= |valid_hit;
			read_owner <= |owner_hit;
		end
	end

	a_sel_onehot: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		$onehot(sel_reg));

endmodule

//--- read_path/read_return_fifo.sv
`timescale 1ns/1ps

module read_return_fifo (
	input logic pll_afi_clk,
	input logic reset_n,
	input logic push,
	input qdr_rd_pkg::data_t wdata,
	input logic pop,
	input logic cal_done,
	output qdr_rd_pkg::rd_rsp_t user_rsp,
	output logic credit
);
	import qdr_rd_pkg::*;

	data_t mem [RET_DEPTH];
	logic [RET_PTR_W-1:0] wr_ptr;
	logic [RET_PTR_W-1:0] rd_ptr;
	logic [RET_PTR_W-1:0] rd_ptr_next;
	logic [RET_CNT_W-1:0] count;
	logic [RET_CNT_W-1:0] head_left;
	logic pop_ok;
	logic cal_done_q;
	logic granted;
	logic [RET_CNT_W-1:0] init_left;

	// a pop is only honoured while the head is actually showing a word
	assign pop_ok = pop & user_rsp.valid;
	assign rd_ptr_next = rd_ptr + RET_PTR_W'(pop_ok);
	assign head_left = count - RET_CNT_W'(pop_ok);

	// the data array is written at the tail on every push
	always_ff @(posedge pll_afi_clk)
	begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			user_rsp <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + RET_PTR_W'(push);
			rd_ptr <= rd_ptr_next;
			count <= head_left + RET_CNT_W'(push);
			// head register shows the oldest entry left after this pop, which
			// puts a pushed word on user_rsp two cycles after its push
			user_rsp.valid <= (head_left != '0);
			user_rsp.data <= mem[rd_ptr_next];
		end
	end

	// the first cal_done grants the full credit pool, one pulse per cycle
	// after that every pop hands exactly one credit back
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cal_done_q <= 1'b0;
			granted <= 1'b0;
			init_left <= '0;
			credit <= 1'b0;
		end
		else
		begin
			cal_done_q <= cal_done;
			if (cal_done && !cal_done_q && !granted)
			begin
				granted <= 1'b1;
				init_left <= RET_CNT_W'(RET_DEPTH);
			end
			else if (init_left != '0)
				init_left <= init_left - 1'b1;
			// no data can be popped before the initial credits are spent
			credit <= (init_left != '0) | pop_ok;
		end
	end

	a_no_overflow: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		push |-> (count != RET_CNT_W'(RET_DEPTH)) || pop_ok);

endmodule

//--- rtl/read_latency_calibrator.sv
`timescale 1ns/1ps

module read_latency_calibrator (
	input logic pll_afi_clk,
	input logic reset_n,
	input logic cal_start,
	input logic rd_strobe,
	input qdr_rd_pkg::data_t rdata,
	output qdr_rd_pkg::rd_req_t cal_req,
	output qdr_rd_pkg::lat_count_t lat_count,
	output logic cal_done,
	output logic cal_fail
);
	import qdr_rd_pkg::*;

	cal_state_t state;
	logic [CAL_WAIT_W-1:0] wait_cnt;
	logic hit;
	logic match;

	// the calibration word only shows up when the strobe lines up with the data
	assign match = rd_strobe && (rdata == CAL_PATTERN);

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= IDLE;
			lat_count <= '0;
			wait_cnt <= '0;
			hit <= 1'b0;
		end
		else if (cal_start)
		begin
			// a restart drops any lock and sweeps again from the shortest latency
			state <= ISSUE;
			lat_count <= '0;
			hit <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// calibration begins on its own once reset is released
					state <= ISSUE;
				end
				ISSUE:
				begin
					hit <= 1'b0;
					wait_cnt <= CAL_WAIT_W'(CAL_WAIT_CYCLES - 1);
					state <= WAIT;
				end
				WAIT:
				begin
					// the window covers the longest candidate latency
					if (match)
						hit <= 1'b1;
					if (wait_cnt == '0)
						state <= CHECK;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				CHECK:
				begin
					if (hit)
						state <= DONE;
					else if (lat_count == lat_count_t'(LAT_NUM - 1))
						state <= FAIL;
					else
					begin
						lat_count <= lat_count + 1'b1;
						state <= ISSUE;
					end
				end
				DONE:
				begin
					state <= DONE;
				end
				FAIL:
				begin
					state <= FAIL;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// one read of the fixed address per trial
	assign cal_req.valid = (state == ISSUE);
	assign cal_req.addr = CAL_ADDR;

	// lat_count keeps its locked value while DONE is held
	assign cal_done = (state == DONE);
	assign cal_fail = (state == FAIL);

	// calibration reads can only come back inside the wait window of their trial
	a_strobe_in_window: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		rd_strobe |-> (state == WAIT));

endmodule

//--- rtl/qdr_read_subsystem.sv
`timescale 1ns/1ps

module qdr_read_subsystem (
	input logic pll_afi_clk,
	input logic reset_n,
	input logic cal_start,
	input qdr_rd_pkg::rd_req_t user_req,
	input logic pop,
	input qdr_rd_pkg::data_t mem_rdata,
	output qdr_rd_pkg::mem_cmd_t mem_cmd,
	output qdr_rd_pkg::rd_rsp_t user_rsp,
	output logic credit,
	output logic cal_done,
	output logic cal_fail
);
	import qdr_rd_pkg::*;

	rd_req_t cal_req;
	logic issue;
	logic issue_owner;
	lat_vec_t lat_shift;
	lat_vec_t owner_shift;
	lat_count_t lat_count;
	logic read_valid;
	logic read_owner;
	logic rd_strobe;
	logic push;

	read_cmd_arbiter u_arbiter (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.cal_req (cal_req),
		.user_req (user_req),
		.mem_cmd (mem_cmd),
		.issue (issue),
		.issue_owner (issue_owner)
	);

	read_latency_shifter u_shifter (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.issue (issue),
		.issue_owner (issue_owner),
		.lat_shift (lat_shift),
		.owner_shift (owner_shift)
	);

	read_valid_selector u_selector (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.lat_shift (lat_shift),
		.owner_shift (owner_shift),
		.lat_count (lat_count),
		.read_valid (read_valid),
		.read_owner (read_owner)
	);

	// owner 0 data feeds the calibrator, owner 1 data goes to the user FIFO
	assign rd_strobe = read_valid & ~read_owner;
	assign push = read_valid & read_owner;

	read_return_fifo u_fifo (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.push (push),
		.wdata (mem_rdata),
		.pop (pop),
		.cal_done (cal_done),
		.user_rsp (user_rsp),
		.credit (credit)
	);

	read_latency_calibrator u_calibrator (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.cal_start (cal_start),
		.rd_strobe (rd_strobe),
		.rdata (mem_rdata),
		.cal_req (cal_req),
		.lat_count (lat_count),
		.cal_done (cal_done),
		.cal_fail (cal_fail)
	);

endmodule

//--- bench/qdr_sram_model.sv
`timescale 1ns/1ps

module qdr_sram_model (
	input logic pll_afi_clk,
	input logic reset_n,
	input logic [4:0] latency,
	input qdr_rd_pkg::data_t salt,
	input qdr_rd_pkg::mem_cmd_t mem_cmd,
	output qdr_rd_pkg::data_t mem_rdata
);
	import qdr_rd_pkg::*;

	// deepest latency the pipe can model
	localparam int MAX_LAT = 16;

	mem_cmd_t pipe [MAX_LAT];
	mem_cmd_t tap;

	// the calibration word sits at its fixed address, every other word is
	// the salted address so each location reads back a distinct value
	function automatic data_t word_at(input addr_t a, input data_t s);
		if (a == CAL_ADDR)
			return CAL_PATTERN;
		return data_t'(a) ^ s;
	endfunction

	// entry j of the pipe holds the command seen j+1 cycles ago
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < MAX_LAT; i++)
				pipe[i] <= '0;
		end
		else
		begin
			pipe[0] <= mem_cmd;
			for (int i = 1; i < MAX_LAT; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	// a command on mem_cmd in cycle c shows its word in cycle c+latency
	// and the bus rests at zero between reads
	always_comb
	begin
		if (latency == '0)
			tap = '0;
		else
			tap = pipe[latency - 1'b1];
		mem_rdata = tap.rd ? word_at(tap.addr, salt) : '0;
	end

endmodule

//--- bench/tb_qdr_read_subsystem.sv
`timescale 1ns/1ps

module tb_qdr_read_subsystem;
	import qdr_rd_pkg::*;

	localparam int CAL_CYCLES = 96;
	localparam int READ_CYCLES = 20;
	// three calibrations, twelve user reads and a margin for the credit waits
	localparam int WATCHDOG_CYCLES = 5 + 3 * (CAL_CYCLES + 4) + 12 * READ_CYCLES + 200;
	localparam data_t SALT = 36'h5_a17c_3e90;
	localparam logic [31:0] RAND_SEED = 32'hea5d590c;

	logic pll_afi_clk;
	logic reset_n;
	logic cal_start;
	rd_req_t user_req;
	logic pop;
	data_t mem_rdata;
	mem_cmd_t mem_cmd;
	rd_rsp_t user_rsp;
	logic credit;
	logic cal_done;
	logic cal_fail;
	logic [4:0] mem_latency;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int credit_total = 0;
	int spent = 0;
	int cal_reads = 0;
	logic cal_phase = 1'b0;
	logic done_seen = 1'b0;
	data_t expect_q[$];

	qdr_read_subsystem DUT (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.cal_start (cal_start),
		.user_req (user_req),
		.pop (pop),
		.mem_rdata (mem_rdata),
		.mem_cmd (mem_cmd),
		.user_rsp (user_rsp),
		.credit (credit),
		.cal_done (cal_done),
		.cal_fail (cal_fail)
	);

	qdr_sram_model u_sram (
		.pll_afi_clk (pll_afi_clk),
		.reset_n (reset_n),
		.latency (mem_latency),
		.salt (SALT),
		.mem_cmd (mem_cmd),
		.mem_rdata (mem_rdata)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #20 pll_afi_clk = ~pll_afi_clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge pll_afi_clk);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	// expected memory content, worked out from the address alone
	function automatic data_t memory_word(input addr_t a);
		if (a == CAL_ADDR)
			return CAL_PATTERN;
		return data_t'(a) ^ SALT;
	endfunction

	function automatic int credits_held();
		return credit_total - spent;
	endfunction

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error at %0t: %s: got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic timeout_error(input string what);
		errors++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("%0t: %s passed", $time, name);
		else
			$display("%0t: %s failed with %0d errors", $time, name, errors - errs_before);
	endtask

	// every drive and sample in the test thread lands 1 ns after the rising edge
	task automatic tick();
		@(posedge pll_afi_clk);
		#1;
	endtask

	// credit pulses are counted at the clock edge, and so are the calibration
	// reads while a calibration is running
	always @(posedge pll_afi_clk)
	begin
		if (reset_n && credit)
		begin
			check(done_seen, 1'b1, "credit pulse before cal_done");
			credit_total++;
		end
		if (cal_done)
			done_seen = 1'b1;
		if (cal_phase && mem_cmd.rd)
		begin
			check(mem_cmd.addr, CAL_ADDR, "calibration read address");
			cal_reads++;
		end
	end

	task automatic wait_cal(input int limit);
		int n = 0;
		while (!cal_done && !cal_fail && n < limit)
		begin
			tick();
			n++;
		end
		if (!cal_done && !cal_fail)
			timeout_error("calibration to finish");
	endtask

	task automatic wait_rsp();
		int n = 0;
		while (!user_rsp.valid && n < READ_CYCLES)
		begin
			tick();
			n++;
		end
		if (!user_rsp.valid)
			timeout_error("a user response");
	endtask

	task automatic wait_credits();
		int n = 0;
		while (credits_held() != RET_DEPTH && n < READ_CYCLES)
		begin
			tick();
			n++;
		end
		if (credits_held() != RET_DEPTH)
			timeout_error("the full credit pool");
	endtask

	// one request cycle spends one credit
	task automatic issue_read(input addr_t a);
		user_req.valid = 1'b1;
		user_req.addr = a;
		spent++;
		tick();
		user_req = '0;
	endtask

	task automatic pop_head();
		pop = 1'b1;
		tick();
		pop = 1'b0;
	endtask

	task automatic single_read();
		addr_t a;
		a = addr_t'($urandom);
		check(credits_held() > 0, 1'b1, "credit held before a user read");
		expect_q.push_back(memory_word(a));
		issue_read(a);
		wait_rsp();
		check(user_rsp.data, expect_q.pop_front(), "user read data");
		pop_head();
	endtask

	task automatic recalibrate(input logic [4:0] latency);
		mem_latency = latency;
		cal_phase = 1'b1;
		cal_start = 1'b1;
		tick();
		cal_start = 1'b0;
		check(cal_done | cal_fail, 1'b0, "status cleared by cal_start");
		wait_cal(CAL_CYCLES + 4);
		cal_phase = 1'b0;
	endtask

	task automatic test_reset_calibration();
		int errs;
		errs = errors;
		mem_latency = 5'd5;
		cal_phase = 1'b1;
		repeat (5) @(posedge pll_afi_clk);
		#1;
		check(mem_cmd.rd | credit | user_rsp.valid | cal_done | cal_fail, 1'b0,
			"outputs low during reset");
		reset_n = 1'b1;
		wait_cal(CAL_CYCLES);
		check(cal_done, 1'b1, "cal_done after reset calibration");
		check(cal_fail, 1'b0, "cal_fail after reset calibration");
		check(cal_reads > 0, 1'b1, "calibration reads seen on mem_cmd");
		cal_phase = 1'b0;
		end_test("reset calibration", errs);
	endtask

	task automatic test_initial_credits();
		int errs;
		errs = errors;
		wait_credits();
		repeat (8) tick();
		check(credit_total, RET_DEPTH, "initial credit count");
		end_test("initial credits", errs);
	endtask

	task automatic test_single_reads();
		int errs;
		errs = errors;
		repeat (6) single_read();
		end_test("single reads", errs);
	endtask

	task automatic test_back_to_back();
		int errs;
		int credits_before;
		addr_t a;
		errs = errors;
		wait_credits();
		// four reads on consecutive cycles use up the whole pool
		for (int i = 0; i < RET_DEPTH; i++)
		begin
			a = addr_t'($urandom);
			expect_q.push_back(memory_word(a));
			user_req.valid = 1'b1;
			user_req.addr = a;
			spent++;
			tick();
		end
		user_req = '0;
		credits_before = credit_total;
		wait_rsp();
		repeat (12) tick();
		check(credit_total, credits_before, "no credit while nothing is popped");
		for (int i = 0; i < RET_DEPTH; i++)
		begin
			check(user_rsp.valid, 1'b1, "head valid before pop");
			check(user_rsp.data, expect_q.pop_front(), "back to back read data");
			pop_head();
			check(credit, 1'b1, "credit one cycle after pop");
		end
		check(user_rsp.valid, 1'b0, "FIFO empty after the last pop");
		repeat (2) tick();
		check(credits_held(), RET_DEPTH, "credit pool refilled by pops");
		end_test("back to back reads", errs);
	endtask

	task automatic test_recal_pass();
		int errs;
		errs = errors;
		recalibrate(5'd9);
		check(cal_done, 1'b1, "cal_done after recalibration at latency 9");
		check(cal_fail, 1'b0, "cal_fail after recalibration at latency 9");
		// the credit pool is granted only once
		check(credits_held(), RET_DEPTH, "credits unchanged by recalibration");
		repeat (2) single_read();
		end_test("recalibration at latency 9", errs);
	endtask

	task automatic test_recal_fail();
		int errs;
		errs = errors;
		repeat (READ_CYCLES) tick();
		recalibrate(5'd12);
		check(cal_fail, 1'b1, "cal_fail at latency 12");
		check(cal_done, 1'b0, "cal_done at latency 12");
		end_test("recalibration at latency 12", errs);
	endtask

	initial
	begin
		reset_n = 1'b0;
		cal_start = 1'b0;
		user_req = '0;
		pop = 1'b0;
		mem_latency = 5'd5;
		void'($urandom(RAND_SEED));
		test_reset_calibration();
		test_initial_credits();
		test_single_reads();
		test_back_to_back();
		test_recal_pass();
		test_recal_fail();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- compile.f
common/qdr_rd_pkg.sv
rtl/read_cmd_arbiter.sv
read_path/read_latency_shifter.sv
read_path/read_valid_selector.sv
read_path/read_return_fifo.sv
rtl/read_latency_calibrator.sv
rtl/qdr_read_subsystem.sv
bench/qdr_sram_model.sv
bench/tb_qdr_read_subsystem.sv
